// File: lsu_settings.svh
// Width, credit and buffer depth defines for the load/store unit
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// Datapath widths
`define LSU_DATA_W 32
`define LSU_ADDR_W 32

// Transaction ID carried from issue to result
`define LSU_TID_W 4

// ----------------------------------------
// Flow control
// ----------------------------------------
// Request slots granted by the data memory after reset
`define LSU_CREDITS 4
// Entries between the issue handshake and the memory port
`define LSU_BUF_DEPTH 2

`endif

// File: lsu_pkg.sv
// Vector typedefs, operation and cause enums, and request/result structs of the LSU
package lsu_pkg;
  `include "lsu_settings.svh"

  typedef logic [`LSU_ADDR_W-1:0] addr_t;
  typedef logic [`LSU_DATA_W-1:0] data_t;
  typedef logic [`LSU_DATA_W/8-1:0] be_t;
  typedef logic [`LSU_TID_W-1:0] tid_t;
  typedef logic [$clog2(`LSU_CREDITS+1)-1:0] credit_t;

  typedef enum logic [2:0] {
    LB, LBU, LH, LHU, LW, SB, SH, SW
  } lsu_op_e;

  // Values follow the RISC-V exception cause codes
  typedef enum logic [3:0] {
    NONE            = 4'd0,
    LD_MISALIGNED   = 4'd4,
    LD_ACCESS_FAULT = 4'd5,
    ST_MISALIGNED   = 4'd6,
    ST_ACCESS_FAULT = 4'd7
  } cause_e;

  // ----------------------------------------
  // Structs
  // ----------------------------------------
  typedef struct packed {
    lsu_op_e op;
    data_t   operand;
    data_t   imm;
    data_t   wdata;
    tid_t    tid;
  } lsu_req_t;

  typedef struct packed {
    lsu_op_e op;
    addr_t   addr;
    be_t     be;
    data_t   wdata;
    tid_t    tid;
    cause_e  cause;
  } lsu_ctrl_t;

  typedef struct packed {
    addr_t addr;
    logic  we;
    be_t   be;
    data_t wdata;
  } mem_req_t;

  typedef struct packed {
    tid_t   tid;
    data_t  data;
    cause_e cause;
    logic   is_store;
  } lsu_result_t;
endpackage

// File: lsu_bounds_regs.sv
// Base and limit registers of the data access window, written by the configuration port
`timescale 1ns/1ps

module lsu_bounds_regs import lsu_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  cfg_we_i,
  input  logic  cfg_sel_i,
  input  addr_t cfg_wdata_i,
  output addr_t base_o,
  output addr_t limit_o
);

  addr_t base_q;
  addr_t limit_q;

  // Sel 0 writes the base, sel 1 the limit
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      base_q  <= '0;
      limit_q <= '1;
    end else if (cfg_we_i) begin
      if (cfg_sel_i) begin
        limit_q <= cfg_wdata_i;
      end else begin
        base_q <= cfg_wdata_i;
      end
    end
  end

  assign base_o  = base_q;
  assign limit_o = limit_q;

endmodule

// File: lsu_agu.sv
// Address generation, byte enables, size decode and misaligned/bounds fault detection
`timescale 1ns/1ps

module lsu_agu import lsu_pkg::*; (
  input  lsu_req_t  req_i,
  input  addr_t     base_i,
  input  addr_t     limit_i,
  output lsu_ctrl_t ctrl_o
);

  addr_t              addr;
  logic               is_store;
  logic [2:0]         size_bytes;
  be_t                size_mask;
  logic               misaligned;
  logic               out_of_bounds;
  logic [`LSU_ADDR_W:0] end_addr;

  assign addr     = base_i + req_i.operand + req_i.imm;
  assign is_store = req_i.op inside {SB, SH, SW};

  // ----------------------------------------
  // Size decode
  // ----------------------------------------
  always_comb begin
    unique case (req_i.op)
      LH, LHU, SH: begin
        size_bytes = 3'd2;
        size_mask  = be_t'(4'b0011);
        misaligned = addr[0];
      end
      LW, SW: begin
        size_bytes = 3'd4;
        size_mask  = be_t'(4'b1111);
        misaligned = (addr[1:0] != 2'b00);
      end
      default: begin
        // Byte accesses are always aligned
        size_bytes = 3'd1;
        size_mask  = be_t'(4'b0001);
        misaligned = 1'b0;
      end
    endcase
  end

  // One extra bit so an access at the top of memory cannot wrap past the limit
  assign end_addr      = {1'b0, addr} + (`LSU_ADDR_W+1)'(size_bytes);
  assign out_of_bounds = end_addr > {1'b0, limit_i};

  // ----------------------------------------
  // Checked entry
  // ----------------------------------------
  always_comb begin
    ctrl_o.op   = req_i.op;
    ctrl_o.addr = addr;
    ctrl_o.be   = size_mask << addr[1:0];
    // Store data moves onto the byte lanes picked by the byte enables
    ctrl_o.wdata = req_i.wdata << {addr[1:0], 3'b000};
    ctrl_o.tid   = req_i.tid;

    // Access fault wins over misalignment
    if (out_of_bounds) begin
      ctrl_o.cause = is_store ? ST_ACCESS_FAULT : LD_ACCESS_FAULT;
    end else if (misaligned) begin
      ctrl_o.cause = is_store ? ST_MISALIGNED : LD_MISALIGNED;
    end else begin
      ctrl_o.cause = NONE;
    end
  end

endmodule

// File: lsu_req_buffer.sv
// Two-entry in-order FIFO between the issue handshake and the memory port
`timescale 1ns/1ps

module lsu_req_buffer import lsu_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      push_i,
  input  lsu_ctrl_t ctrl_i,
  output logic      ready_o,
  output logic      head_valid_o,
  output lsu_ctrl_t head_o,
  input  logic      pop_i
);
  `include "lsu_settings.svh"

  localparam int unsigned DEPTH = `LSU_BUF_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [$clog2(DEPTH+1)-1:0] cnt_t;

  lsu_ctrl_t mem_q [DEPTH];
  ptr_t      wr_ptr_q;
  ptr_t      rd_ptr_q;
  cnt_t      cnt_q;
  logic      do_push;
  logic      do_pop;

  assign ready_o      = (cnt_q != cnt_t'(DEPTH));
  assign head_valid_o = (cnt_q != '0);
  assign head_o       = mem_q[rd_ptr_q];

  // A push while full is dropped here and never seen by the issue side
  assign do_push = push_i && ready_o;
  assign do_pop  = pop_i && head_valid_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == ptr_t'(DEPTH-1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_t'(DEPTH-1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (do_pop && !do_push) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= ctrl_i;
    end
  end

endmodule

// File: lsu_mem_port.sv
// Credit counter, memory request issue, outstanding FIFO, load alignment and result return
`timescale 1ns/1ps

module lsu_mem_port import lsu_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        head_valid_i,
  input  lsu_ctrl_t   head_i,
  output logic        pop_o,
  output logic        mem_req_valid_o,
  output mem_req_t    mem_req_o,
  input  logic        mem_credit_i,
  input  logic        mem_rsp_valid_i,
  input  data_t       mem_rsp_rdata_i,
  output logic        result_valid_o,
  output lsu_result_t result_o
);
  `include "lsu_settings.svh"

  localparam int unsigned PEND_DEPTH = `LSU_CREDITS;
  localparam int unsigned PTR_W      = (PEND_DEPTH > 1) ? $clog2(PEND_DEPTH) : 1;

  typedef logic [PTR_W-1:0] ptr_t;

  // What the response needs to rebuild the result
  typedef struct packed {
    tid_t       tid;
    lsu_op_e    op;
    logic [1:0] lsb;
  } pend_t;

  credit_t     credit_q;
  credit_t     pend_cnt_q;
  pend_t       pend_q [PEND_DEPTH];
  ptr_t        pend_wr_q;
  ptr_t        pend_rd_q;
  pend_t       pend_head;
  logic        issue;
  logic        fault_post;
  data_t       rsp_shifted;
  data_t       load_data;
  lsu_result_t result_d;
  lsu_result_t result_q;
  logic        result_valid_q;

  // ----------------------------------------
  // Request issue
  // ----------------------------------------
  assign issue = head_valid_i && (head_i.cause == NONE) && (credit_q != '0)
                 && (pend_cnt_q != credit_t'(PEND_DEPTH));
  // Faulting head drains behind all older requests
  assign fault_post = head_valid_i && (head_i.cause != NONE) && (pend_cnt_q == '0);
  assign pop_o      = issue || fault_post;

  assign mem_req_valid_o = issue;
  assign mem_req_o.addr  = head_i.addr;
  assign mem_req_o.we    = head_i.op inside {SB, SH, SW};
  assign mem_req_o.be    = head_i.be;
  assign mem_req_o.wdata = head_i.wdata;

  // Credit and outstanding bookkeeping
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q   <= credit_t'(`LSU_CREDITS);
      pend_cnt_q <= '0;
      pend_wr_q  <= '0;
      pend_rd_q  <= '0;
    end else begin
      if (issue && !mem_credit_i) begin
        credit_q <= credit_q - 1'b1;
      end else if (mem_credit_i && !issue) begin
        credit_q <= credit_q + 1'b1;
      end
      if (issue && !mem_rsp_valid_i) begin
        pend_cnt_q <= pend_cnt_q + 1'b1;
      end else if (mem_rsp_valid_i && !issue) begin
        pend_cnt_q <= pend_cnt_q - 1'b1;
      end
      if (issue) begin
        pend_wr_q <= (pend_wr_q == ptr_t'(PEND_DEPTH-1)) ? '0 : pend_wr_q + 1'b1;
      end
      if (mem_rsp_valid_i) begin
        pend_rd_q <= (pend_rd_q == ptr_t'(PEND_DEPTH-1)) ? '0 : pend_rd_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue) begin
      pend_q[pend_wr_q] <= '{tid: head_i.tid, op: head_i.op, lsb: head_i.addr[1:0]};
    end
  end

  assign pend_head = pend_q[pend_rd_q];

  // ----------------------------------------
  // Load alignment and result
  // ----------------------------------------
  assign rsp_shifted = mem_rsp_rdata_i >> {pend_head.lsb, 3'b000};

  always_comb begin
    unique case (pend_head.op)
      LB:      load_data = {{(`LSU_DATA_W-8){rsp_shifted[7]}}, rsp_shifted[7:0]};
      LBU:     load_data = {{(`LSU_DATA_W-8){1'b0}}, rsp_shifted[7:0]};
      LH:      load_data = {{(`LSU_DATA_W-16){rsp_shifted[15]}}, rsp_shifted[15:0]};
      LHU:     load_data = {{(`LSU_DATA_W-16){1'b0}}, rsp_shifted[15:0]};
      LW:      load_data = mem_rsp_rdata_i;
      default: load_data = '0;  // stores return zero
    endcase
  end

  always_comb begin
    if (mem_rsp_valid_i) begin
      result_d.tid      = pend_head.tid;
      result_d.data     = load_data;
      result_d.cause    = NONE;
      result_d.is_store = pend_head.op inside {SB, SH, SW};
    end else begin
      result_d.tid      = head_i.tid;
      result_d.data     = '0;
      result_d.cause    = head_i.cause;
      result_d.is_store = head_i.op inside {SB, SH, SW};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      result_valid_q <= 1'b0;
    end else begin
      result_valid_q <= mem_rsp_valid_i || fault_post;
    end
  end

  always_ff @(posedge clk_i) begin
    if (mem_rsp_valid_i || fault_post) begin
      result_q <= result_d;
    end
  end

  assign result_valid_o = result_valid_q;
  assign result_o       = result_q;

endmodule

// File: lsu_top.sv
// LSU top level joining bounds registers, AGU, request buffer and memory port
`timescale 1ns/1ps

module lsu_top import lsu_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  // Issue side
  input  logic        req_valid_i,
  input  lsu_req_t    req_i,
  output logic        req_ready_o,
  // Configuration
  input  logic        cfg_we_i,
  input  logic        cfg_sel_i,
  input  addr_t       cfg_wdata_i,
  // Data memory
  output logic        mem_req_valid_o,
  output mem_req_t    mem_req_o,
  input  logic        mem_credit_i,
  input  logic        mem_rsp_valid_i,
  input  data_t       mem_rsp_rdata_i,
  // Results
  output logic        result_valid_o,
  output lsu_result_t result_o
);

  addr_t     base;
  addr_t     limit;
  lsu_ctrl_t agu_ctrl;
  logic      head_valid;
  lsu_ctrl_t head;
  logic      pop;

  lsu_bounds_regs i_bounds_regs (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cfg_we_i    (cfg_we_i),
    .cfg_sel_i   (cfg_sel_i),
    .cfg_wdata_i (cfg_wdata_i),
    .base_o      (base),
    .limit_o     (limit)
  );

  lsu_agu i_agu (
    .req_i   (req_i),
    .base_i  (base),
    .limit_i (limit),
    .ctrl_o  (agu_ctrl)
  );

  // Push is the issue handshake itself
  lsu_req_buffer i_req_buffer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .push_i       (req_valid_i && req_ready_o),
    .ctrl_i       (agu_ctrl),
    .ready_o      (req_ready_o),
    .head_valid_o (head_valid),
    .head_o       (head),
    .pop_i        (pop)
  );

  lsu_mem_port i_mem_port (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .head_valid_i    (head_valid),
    .head_i          (head),
    .pop_o           (pop),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_o       (mem_req_o),
    .mem_credit_i    (mem_credit_i),
    .mem_rsp_valid_i (mem_rsp_valid_i),
    .mem_rsp_rdata_i (mem_rsp_rdata_i),
    .result_valid_o  (result_valid_o),
    .result_o        (result_o)
  );

endmodule

// File: lsu_sva.sv
// Credit, outstanding-count and response assertions bound into the memory port
`timescale 1ns/1ps

module lsu_sva import lsu_pkg::*; (
  input logic    clk_i,
  input logic    rst_ni,
  input logic    mem_req_valid_o,
  input logic    mem_rsp_valid_i,
  input credit_t credit_q,
  input credit_t pend_cnt_q
);
  `include "lsu_settings.svh"

  credit_before_request: assert property (
    @(posedge clk_i) disable iff (!rst_ni) mem_req_valid_o |-> (credit_q != '0)
  ) else $error("Memory request issued with no credit left");

  outstanding_bounded: assert property (
    @(posedge clk_i) disable iff (!rst_ni) pend_cnt_q <= credit_t'(`LSU_CREDITS)
  ) else $error("More requests outstanding than memory slots");

  credit_bounded: assert property (
    @(posedge clk_i) disable iff (!rst_ni) credit_q <= credit_t'(`LSU_CREDITS)
  ) else $error("Credit count above its reset value");

  // Each response answers one request still in flight
  response_has_request: assert property (
    @(posedge clk_i) disable iff (!rst_ni) mem_rsp_valid_i |-> (pend_cnt_q != '0)
  ) else $error("Memory response with no request outstanding");

endmodule

bind lsu_mem_port lsu_sva i_sva (
  .clk_i           (clk_i),
  .rst_ni          (rst_ni),
  .mem_req_valid_o (mem_req_valid_o),
  .mem_rsp_valid_i (mem_rsp_valid_i),
  .credit_q        (credit_q),
  .pend_cnt_q      (pend_cnt_q)
);

// File: lsu_checker.sv
// Result checker with expected queue filled on the issue handshake, field compares and count line
`timescale 1ns/1ps

module lsu_checker import lsu_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        req_valid_i,
  input  logic        req_ready_i,
  input  logic        mem_req_valid_i,
  input  lsu_result_t exp_i,
  input  logic        result_valid_i,
  input  lsu_result_t result_i,
  input  logic        end_i,
  input  int          tb_err_i,
  output int          err_cnt_o,
  output int          res_cnt_o
);

  lsu_result_t exp_q [$];
  lsu_result_t want;
  int          errors = 0;
  int          results = 0;
  logic        reset_checked = 1'b0;

  task automatic compare_field(input string name, input data_t got, input data_t expected,
                               input tid_t tid);
    if (got !== expected) begin
      $display("Error: %s is %h, expected %h (tid %h)", name, got, expected, tid);
      errors++;
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic expected);
    if (got !== expected) begin
      $display("Error: %s is %h right after reset, expected %h", name, got, expected);
      errors++;
    end
  endtask

  // Sampled mid-cycle where DUT outputs are settled
  always @(negedge clk_i) begin
    // Registers still hold their reset values before the first edge out of reset
    if (rst_ni === 1'b1 && !reset_checked) begin
      reset_checked = 1'b1;
      check_level("req_ready_o", req_ready_i, 1'b1);
      check_level("mem_req_valid_o", mem_req_valid_i, 1'b0);
      check_level("result_valid_o", result_valid_i, 1'b0);
    end
    if (rst_ni === 1'b1) begin
      if (result_valid_i === 1'b1) begin
        results++;
        if (exp_q.size() == 0) begin
          $display("A result with tid %h came back with no operation waiting for it",
                   result_i.tid);
          errors++;
        end else begin
          want = exp_q.pop_front();
          compare_field("result_o.tid", data_t'(result_i.tid), data_t'(want.tid), want.tid);
          compare_field("result_o.data", result_i.data, want.data, want.tid);
          compare_field("result_o.cause", data_t'(result_i.cause), data_t'(want.cause),
                        want.tid);
          compare_field("result_o.is_store", data_t'(result_i.is_store),
                        data_t'(want.is_store), want.tid);
        end
      end
      if (req_valid_i === 1'b1 && req_ready_i === 1'b1) begin
        exp_q.push_back(exp_i);
      end
    end
  end

  // ----------------------------------------
  // End of run
  // ----------------------------------------
  always @(posedge end_i) begin
    while (exp_q.size() != 0) begin
      want = exp_q.pop_front();
      $display("No result came back for the operation with tid %h", want.tid);
      errors++;
    end
    $display("Results checked: %0d, checker errors: %0d, testbench errors: %0d",
             results, errors, tb_err_i);
  end

  assign err_cnt_o = errors;
  assign res_cnt_o = results;

endmodule

// File: tb_lsu.sv
// Testbench top with clock, reset, stim file stimulus, credit memory model, DUT and timeout
`timescale 1ns/1ps

module tb_lsu import lsu_pkg::*; ();
  `include "lsu_settings.svh"

  // One line of the stim file
  typedef struct packed {
    logic [3:0] kind;
    logic [3:0] op;
    data_t      operand;
    data_t      imm;
    data_t      wdata;
    tid_t       tid;
    data_t      exp_data;
    logic [3:0] exp_cause;
  } stim_t;

  typedef struct packed {
    mem_req_t    req;
    logic [31:0] due;
  } mem_slot_t;

  logic        clk_i;
  logic        rst_ni;
  logic        req_valid;
  lsu_req_t    req;
  logic        req_ready;
  logic        cfg_we;
  logic        cfg_sel;
  addr_t       cfg_wdata;
  logic        mem_req_valid;
  mem_req_t    mem_req;
  logic        mem_credit;
  logic        mem_rsp_valid;
  data_t       mem_rsp_rdata;
  logic        result_valid;
  lsu_result_t result;
  lsu_result_t exp;
  logic        end_run;
  logic        limit_set;
  int          tb_errors;
  int          chk_errors;
  int          res_cnt;
  int          mem_req_cnt;
  int unsigned cycle_cnt = 0;
  int unsigned cycle_limit;
  stim_t       stim_q [$];
  mem_slot_t   mem_q [$];
  mem_slot_t   cap_slot;
  mem_slot_t   rsp_slot;
  data_t       mem [256];

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  lsu_top UUT (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_valid_i     (req_valid),
    .req_i           (req),
    .req_ready_o     (req_ready),
    .cfg_we_i        (cfg_we),
    .cfg_sel_i       (cfg_sel),
    .cfg_wdata_i     (cfg_wdata),
    .mem_req_valid_o (mem_req_valid),
    .mem_req_o       (mem_req),
    .mem_credit_i    (mem_credit),
    .mem_rsp_valid_i (mem_rsp_valid),
    .mem_rsp_rdata_i (mem_rsp_rdata),
    .result_valid_o  (result_valid),
    .result_o        (result)
  );

  lsu_checker i_checker (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_valid_i     (req_valid),
    .req_ready_i     (req_ready),
    .mem_req_valid_i (mem_req_valid),
    .exp_i           (exp),
    .result_valid_i  (result_valid),
    .result_i        (result),
    .end_i           (end_run),
    .tb_err_i        (tb_errors),
    .err_cnt_o       (chk_errors),
    .res_cnt_o       (res_cnt)
  );

  // ----------------------------------------
  // Memory model
  // ----------------------------------------
  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i] = 32'h9e3779b9 * (i + 1);
    end
  end

  // Requests are taken while stable, before the edge that the DUT issues on
  always @(negedge clk_i) begin
    if (rst_ni === 1'b1 && mem_req_valid === 1'b1) begin
      cap_slot.req = mem_req;
      cap_slot.due = cycle_cnt + 32'd1 + ($urandom % 32'd6);
      mem_q.push_back(cap_slot);
      mem_req_cnt++;
      if (mem_q.size() > `LSU_CREDITS) begin
        $display("Memory got more requests than it has slots at cycle %0d", cycle_cnt);
        tb_errors++;
      end
    end
  end

  // In-order responses that each return one credit
  always @(posedge clk_i) begin
    #2;
    mem_rsp_valid = 1'b0;
    mem_credit    = 1'b0;
    if (mem_q.size() != 0 && mem_q[0].due <= cycle_cnt) begin
      rsp_slot = mem_q.pop_front();
      if (rsp_slot.req.we) begin
        for (int b = 0; b < 4; b++) begin
          if (rsp_slot.req.be[b]) begin
            mem[rsp_slot.req.addr[9:2]][8*b +: 8] = rsp_slot.req.wdata[8*b +: 8];
          end
        end
      end
      mem_rsp_rdata = mem[rsp_slot.req.addr[9:2]];
      mem_rsp_valid = 1'b1;
      mem_credit    = 1'b1;
    end
  end

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  task automatic write_cfg(input logic sel, input addr_t value);
    cfg_we    = 1'b1;
    cfg_sel   = sel;
    cfg_wdata = value;
    @(posedge clk_i);
    #2;
    cfg_we = 1'b0;
  endtask

  task automatic issue_op(input stim_t s);
    logic accepted;
    req.op        = lsu_op_e'(s.op[2:0]);
    req.operand   = s.operand;
    req.imm       = s.imm;
    req.wdata     = s.wdata;
    req.tid       = s.tid;
    exp.tid       = s.tid;
    exp.data      = s.exp_data;
    exp.cause     = cause_e'(s.exp_cause);
    exp.is_store  = (s.op >= 4'd5);
    req_valid     = 1'b1;
    accepted      = 1'b0;
    // Ready only moves on a clock edge, so it is stable here
    while (!accepted) begin
      accepted = req_ready;
      @(posedge clk_i);
      #2;
    end
    req_valid = 1'b0;
  endtask

  initial begin : stimulus
    int         fd;
    int         n;
    int         n_ops;
    int         exp_reqs;
    int         gap;
    string      line;
    stim_t      s;
    logic [3:0] f_kind;
    logic [3:0] f_op;
    logic [3:0] f_cause;
    tid_t       f_tid;
    data_t      f_operand;
    data_t      f_imm;
    data_t      f_wdata;
    data_t      f_exp;

    void'($urandom(32'h834dc1ce));
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    req_valid     = 1'b0;
    req           = '0;
    exp           = '0;
    cfg_we        = 1'b0;
    cfg_sel       = 1'b0;
    cfg_wdata     = '0;
    mem_credit    = 1'b0;
    mem_rsp_valid = 1'b0;
    mem_rsp_rdata = '0;
    end_run       = 1'b0;
    limit_set     = 1'b0;
    tb_errors     = 0;
    mem_req_cnt   = 0;
    n_ops         = 0;
    exp_reqs      = 0;

    fd = $fopen("lsu_stim.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file lsu_stim.txt");
      tb_errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        n = $sscanf(line, "%h %h %h %h %h %h %h %h", f_kind, f_op, f_operand, f_imm,
                    f_wdata, f_tid, f_exp, f_cause);
        if (n == 8) begin
          s = '{f_kind, f_op, f_operand, f_imm, f_wdata, f_tid, f_exp, f_cause};
          stim_q.push_back(s);
          if (f_kind == 4'd0) begin
            n_ops++;
            if (f_cause == 4'd0) begin
              exp_reqs++;
            end
          end
        end
      end
      $fclose(fd);
    end

    cycle_limit = 200 * n_ops + 100;
    limit_set   = 1'b1;

    repeat (8) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    for (int k = 0; k < stim_q.size(); k++) begin
      if (stim_q[k].kind == 4'd1) begin
        write_cfg(stim_q[k].op[0], stim_q[k].operand);
      end else begin
        // Half the operations go back to back
        gap = ($urandom % 2) ? 0 : int'($urandom % 3);
        repeat (gap) begin
          @(posedge clk_i);
          #2;
        end
        issue_op(stim_q[k]);
      end
    end

    while (res_cnt < n_ops) @(posedge clk_i);
    // A few more cycles to catch stray results
    repeat (10) @(posedge clk_i);

    if (mem_req_cnt != exp_reqs) begin
      $display("Memory saw %0d requests where %0d were expected", mem_req_cnt, exp_reqs);
      tb_errors++;
    end

    end_run = 1'b1;
    #1;
    if (chk_errors + tb_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    wait (limit_set === 1'b1);
    while (cycle_cnt < cycle_limit) @(posedge clk_i);
    $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
    tb_errors++;
    end_run = 1'b1;
    #1;
    $display("TEST FAIL");
    $finish;
  end

endmodule

// File: lsu_stim.txt
// kind op operand imm wdata tid exp_data exp_cause, all hex
// kind 0 issues op 0..7 (LB LBU LH LHU LW SB SH SW); kind 1 writes base (op 0) or limit (op 1)
1 0 00000040 00000000 00000000 0 00000000 0
0 7 00000008 00000008 11223344 1 00000000 0
0 5 00000010 00000001 000000ab 2 00000000 0
0 7 00000014 00000000 cafef00d 3 00000000 0
0 6 00000010 00000006 00008001 4 00000000 0
1 0 00000000 00000000 00000000 0 00000000 0
0 0 00000050 00000001 00000000 5 ffffffab 0
0 1 00000040 00000011 00000000 6 000000ab 0
0 2 00000056 00000000 00000000 7 ffff8001 0
0 3 00000050 00000006 00000000 8 00008001 0
0 4 00000050 00000000 00000000 9 1122ab44 0
0 0 00000052 00000001 00000000 a 00000011 0
0 2 00000054 00000000 00000000 b fffff00d 0
0 2 00000055 00000000 00000000 c 00000000 4
0 7 00000050 00000002 12345678 d 00000000 6
0 4 00000050 00000004 00000000 e 8001f00d 0
1 1 00000100 00000000 00000000 0 00000000 0
0 7 000000f0 0000000c 5a5a5a5a f 00000000 0
0 4 000000fd 00000000 00000000 0 00000000 5
0 6 000000ff 00000000 00008001 1 00000000 7
0 1 000000f0 0000000f 00000000 2 0000005a 0
0 5 00000100 00000000 000000aa 3 00000000 7
0 4 000000fc 00000000 00000000 4 5a5a5a5a 0

// File: files.f
+incdir+.
lsu_pkg.sv
lsu_bounds_regs.sv
lsu_agu.sv
lsu_req_buffer.sv
lsu_mem_port.sv
lsu_top.sv
lsu_sva.sv
lsu_checker.sv
tb_lsu.sv

// File: run.sh
#!/bin/sh
# Build the LSU testbench with Verilator, run it and scan the log for failure
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_lsu -f files.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_lsu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAIL" sim.log; then
  exit 1
fi
exit 0
